//--- logic/addrgen_pkg.sv
// Shared widths, page constants, operation encodings and request structs
package addrgen_pkg;

  ////////////////////
  // Bus and vector widths

  // Address bus width in bits
  parameter int unsigned AddrWidth     = 32;
  // Bytes moved per data beat
  parameter int unsigned DataBytes     = 8;
  parameter int unsigned DataBytesLog  = $clog2(DataBytes);
  // Element count width
  parameter int unsigned VlWidth       = 16;

  ////////////////////
  // AXI burst limits

  // 4 KiB page, bursts never cross it
  parameter int unsigned PageBits      = 12;
  // Longest INCR burst in beats
  parameter int unsigned MaxBurstBeats = 256;

  ////////////////////
  // Basic types

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [VlWidth-1:0]   vl_t;

  // Element width, encoded as log2 of bytes per element
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Supported vector memory operations
  typedef enum logic [1:0] {
    OP_UNIT_LOAD,
    OP_UNIT_STORE,
    OP_STRIDE_LOAD,
    OP_STRIDE_STORE
  } mem_op_e;

  ////////////////////
  // Request structs

  // Request as it arrives from the sequencer
  typedef struct packed {
    mem_op_e op;
    addr_t   addr;
    vl_t     vl;
    addr_t   stride;
    vew_e    vew;
  } mem_req_t;

  // Checked job for one of the generators
  typedef struct packed {
    addr_t addr;
    vl_t   len;
    addr_t stride;
    vew_e  vew;
    logic  is_load;
  } mem_job_t;

  // One AR or AW beat, also copied to the load/store units
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic       is_load;
  } ax_beat_t;

endpackage

//--- logic/addr_queue.sv
// Circular FIFO of beat descriptors for the load/store units
`timescale 1ns/1ps

module addr_queue #(
  parameter int unsigned QueueDepth = 4,
  parameter type         dtype      = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic full_o,
  output logic empty_o
);

  // Pointer needs at least one bit
  localparam int unsigned PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  dtype                mem_q [QueueDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;
  logic                do_push;
  logic                do_pop;

  // Push into a full queue or pop from an empty one is dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign full_o  = (cnt_q == CntWidth'(QueueDepth));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Wrap explicitly, depth need not be a power of two
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- logic/op_decoder.sv
// Request decoder with alignment check, generator start and acknowledge
`timescale 1ns/1ps

module op_decoder (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  addrgen_pkg::mem_req_t req_i,
  input  logic                  req_valid_i,
  input  logic                  gen_done_i,
  output addrgen_pkg::mem_job_t job_o,
  output logic                  burst_start_o,
  output logic                  stride_start_o,
  output logic                  ack_o,
  output logic                  error_o
);

  typedef enum logic {
    IDLE,
    BUSY
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   accept;
  logic   misaligned;
  logic   is_unit;
  logic   is_load;

  // Base address must be a multiple of the element size
  function automatic logic is_misaligned(addrgen_pkg::addr_t addr, addrgen_pkg::vew_e vew);
    addrgen_pkg::addr_t mask;
    mask = (addrgen_pkg::addr_t'(1) << vew) - 1'b1;
    return |(addr & mask);
  endfunction

  // Request is held until ack, so skip the ack cycle itself
  assign accept     = (state_q == IDLE) && req_valid_i && !ack_o;
  assign misaligned = is_misaligned(req_i.addr, req_i.vew);
  assign is_unit    = (req_i.op == addrgen_pkg::OP_UNIT_LOAD) ||
                      (req_i.op == addrgen_pkg::OP_UNIT_STORE);
  assign is_load    = (req_i.op == addrgen_pkg::OP_UNIT_LOAD) ||
                      (req_i.op == addrgen_pkg::OP_STRIDE_LOAD);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Misaligned request is rejected without leaving IDLE
        if (accept && !misaligned) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        if (gen_done_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      burst_start_o  <= 1'b0;
      stride_start_o <= 1'b0;
      ack_o          <= 1'b0;
      error_o        <= 1'b0;
    end else begin
      state_q        <= state_d;
      // Strobes one cycle after acceptance
      burst_start_o  <= accept && !misaligned && is_unit;
      stride_start_o <= accept && !misaligned && !is_unit;
      // Ack on error, or one cycle after the last beat
      ack_o          <= (accept && misaligned) || ((state_q == BUSY) && gen_done_i);
      error_o        <= accept && misaligned;
    end
  end

  // Job fields translated from the request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      job_o.addr    <= req_i.addr;
      job_o.len     <= req_i.vl;
      job_o.stride  <= req_i.stride;
      job_o.vew     <= req_i.vew;
      job_o.is_load <= is_load;
    end
  end

endmodule

//--- logic/burst_splitter.sv
// Unit-stride generator splitting jobs into page-bounded INCR bursts
`timescale 1ns/1ps

module burst_splitter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  addrgen_pkg::mem_job_t job_i,
  input  logic                  start_i,
  input  logic                  core_st_pending_i,
  input  logic                  beat_taken_i,
  output addrgen_pkg::ax_beat_t beat_o,
  output logic                  beat_valid_o,
  output logic                  done_o
);

  // Byte count of a whole job, EW64 shifts by three
  localparam int unsigned ByteWidth  = addrgen_pkg::VlWidth + 3;
  localparam int unsigned BurstBytes = addrgen_pkg::MaxBurstBeats * addrgen_pkg::DataBytes;

  typedef logic [ByteWidth-1:0] bytes_t;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    WAIT,
    REQ
  } state_e;

  state_e             state_q;
  state_e             state_d;
  addrgen_pkg::addr_t addr_q;
  addrgen_pkg::addr_t addr_d;
  addrgen_pkg::addr_t end_q;
  addrgen_pkg::addr_t end_d;
  bytes_t             rem_q;
  bytes_t             rem_d;
  logic               is_load_q;
  addrgen_pkg::addr_t start_aligned;
  addrgen_pkg::addr_t consumed;
  addrgen_pkg::addr_t nxt_addr;
  bytes_t             nxt_rem;
  logic               last;

  // Last byte of the next burst
  // Smallest of operation end, burst length limit and page end
  function automatic addrgen_pkg::addr_t burst_end(addrgen_pkg::addr_t addr, bytes_t bytes);
    addrgen_pkg::addr_t beat_mask;
    addrgen_pkg::addr_t op_end;
    addrgen_pkg::addr_t len_end;
    addrgen_pkg::addr_t page_end;
    addrgen_pkg::addr_t res;
    beat_mask = addrgen_pkg::addr_t'(addrgen_pkg::DataBytes - 1);
    op_end    = (addr + addrgen_pkg::addr_t'(bytes) - 1'b1) | beat_mask;
    len_end   = (addr & ~beat_mask) + addrgen_pkg::addr_t'(BurstBytes - 1);
    page_end  = addr | addrgen_pkg::addr_t'((1 << addrgen_pkg::PageBits) - 1);
    res       = op_end;
    if (len_end < res) begin
      res = len_end;
    end
    if (page_end < res) begin
      res = page_end;
    end
    return res;
  endfunction

  // Only the first burst can start off a beat boundary
  assign start_aligned = addr_q & ~addrgen_pkg::addr_t'(addrgen_pkg::DataBytes - 1);
  assign consumed      = end_q - addr_q + 1'b1;
  assign last          = (addrgen_pkg::addr_t'(rem_q) <= consumed);
  assign nxt_addr      = end_q + 1'b1;
  assign nxt_rem       = last ? '0 : rem_q - bytes_t'(consumed);

  // Full bus width on every beat
  assign beat_o.addr    = addr_q;
  assign beat_o.len     = 8'((end_q - start_aligned) >> addrgen_pkg::DataBytesLog);
  assign beat_o.size    = 3'(addrgen_pkg::DataBytesLog);
  assign beat_o.is_load = is_load_q;
  assign beat_valid_o   = (state_q == REQ);
  assign done_o         = beat_taken_i && last;

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    rem_d   = rem_q;
    end_d   = end_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = CALC;
          addr_d  = job_i.addr;
          rem_d   = bytes_t'(job_i.len) << job_i.vew;
        end
      end
      CALC: begin
        // First boundaries, then hold off while a core store is pending
        end_d   = burst_end(addr_q, rem_q);
        state_d = core_st_pending_i ? WAIT : REQ;
      end
      WAIT: begin
        if (!core_st_pending_i) begin
          state_d = REQ;
        end
      end
      REQ: begin
        // Next burst begins right after this one
        if (beat_taken_i) begin
          addr_d = nxt_addr;
          rem_d  = nxt_rem;
          end_d  = burst_end(nxt_addr, nxt_rem);
          if (last) begin
            state_d = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    rem_q  <= rem_d;
    end_q  <= end_d;
    if ((state_q == IDLE) && start_i) begin
      is_load_q <= job_i.is_load;
    end
  end

endmodule

//--- logic/stride_stepper.sv
// Strided generator issuing one single-beat request per element
`timescale 1ns/1ps

module stride_stepper (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  addrgen_pkg::mem_job_t job_i,
  input  logic                  start_i,
  input  logic                  core_st_pending_i,
  input  logic                  beat_taken_i,
  output addrgen_pkg::ax_beat_t beat_o,
  output logic                  beat_valid_o,
  output logic                  done_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    REQ
  } state_e;

  state_e             state_q;
  addrgen_pkg::addr_t addr_q;
  addrgen_pkg::addr_t stride_q;
  addrgen_pkg::vl_t   rem_q;
  addrgen_pkg::vew_e  vew_q;
  logic               is_load_q;

  // One element per beat, size follows the element width
  assign beat_o.addr    = addr_q;
  assign beat_o.len     = 8'd0;
  assign beat_o.size    = 3'(vew_q);
  assign beat_o.is_load = is_load_q;
  assign beat_valid_o   = (state_q == REQ);
  assign done_o         = beat_taken_i && (rem_q == addrgen_pkg::vl_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          // First beat waits out a pending core store
          if (start_i) begin
            state_q <= core_st_pending_i ? WAIT : REQ;
          end
        end
        WAIT: begin
          if (!core_st_pending_i) begin
            state_q <= REQ;
          end
        end
        REQ: begin
          if (done_o) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Address walks by the stride, count walks down to one
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && start_i) begin
      addr_q    <= job_i.addr;
      stride_q  <= job_i.stride;
      rem_q     <= job_i.len;
      vew_q     <= job_i.vew;
      is_load_q <= job_i.is_load;
    end else if (beat_taken_i) begin
      addr_q <= addr_q + stride_q;
      rem_q  <= rem_q - 1'b1;
    end
  end

endmodule

//--- logic/ax_issue.sv
// Issue stage steering beats to AR or AW and filling the LSU queue
`timescale 1ns/1ps

module ax_issue (
  input  addrgen_pkg::ax_beat_t burst_beat_i,
  input  logic                  burst_valid_i,
  input  addrgen_pkg::ax_beat_t stride_beat_i,
  input  logic                  stride_valid_i,
  input  logic                  ar_ready_i,
  input  logic                  aw_ready_i,
  input  logic                  q_full_i,
  input  logic                  q_empty_i,
  input  logic                  q_head_load_i,
  output addrgen_pkg::ax_beat_t ar_o,
  output logic                  ar_valid_o,
  output addrgen_pkg::ax_beat_t aw_o,
  output logic                  aw_valid_o,
  output logic                  q_push_o,
  output addrgen_pkg::ax_beat_t q_data_o,
  output logic                  burst_taken_o,
  output logic                  stride_taken_o
);

  addrgen_pkg::ax_beat_t sel_beat;
  logic                  sel_valid;
  logic                  ch_ready;
  logic                  dir_ok;
  logic                  take;

  ////////////////////
  // Source select

  // Only one job runs at a time, so at most one source is valid
  assign sel_beat  = burst_valid_i ? burst_beat_i : stride_beat_i;
  assign sel_valid = burst_valid_i || stride_valid_i;

  ////////////////////
  // Issue rule

  // Ready of the channel this beat goes to
  assign ch_ready = sel_beat.is_load ? ar_ready_i : aw_ready_i;

  // No direction change while older beats are still queued
  // Keeps load and store responses in order for the LSUs
  assign dir_ok = q_empty_i || (q_head_load_i == sel_beat.is_load);

  assign take = sel_valid && !q_full_i && ch_ready && dir_ok;

  ////////////////////
  // Channel steering

  assign ar_o       = sel_beat;
  assign aw_o       = sel_beat;
  assign ar_valid_o = take && sel_beat.is_load;
  assign aw_valid_o = take && !sel_beat.is_load;

  // Same beat copied to the queue
  assign q_push_o = take;
  assign q_data_o = sel_beat;

  // Taken goes back to whichever generator offered the beat
  assign burst_taken_o  = take && burst_valid_i;
  assign stride_taken_o = take && !burst_valid_i;

endmodule

//--- logic/addrgen_top.sv
// Address generator top with decoder, generators, issue stage and queue
`timescale 1ns/1ps

module addrgen_top #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Request side
  input  addrgen_pkg::mem_req_t req_i,
  input  logic                  req_valid_i,
  input  logic                  core_st_pending_i,
  output logic                  ack_o,
  output logic                  error_o,
  // AXI address channels
  output addrgen_pkg::ax_beat_t ar_o,
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output addrgen_pkg::ax_beat_t aw_o,
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  // Load/store units
  output addrgen_pkg::ax_beat_t lsu_req_o,
  output logic                  lsu_req_valid_o,
  input  logic                  lsu_req_ready_i
);

  addrgen_pkg::mem_job_t job;
  logic                  burst_start, stride_start;
  addrgen_pkg::ax_beat_t burst_beat, stride_beat, q_data;
  logic                  burst_valid, stride_valid;
  logic                  burst_taken, stride_taken;
  logic                  burst_done, stride_done;
  logic                  q_push, q_full, q_empty;

  op_decoder i_decoder (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .gen_done_i    (burst_done | stride_done),
    .job_o         (job),
    .burst_start_o (burst_start),
    .stride_start_o(stride_start),
    .ack_o         (ack_o),
    .error_o       (error_o)
  );

  burst_splitter i_burst (
    .clk_i, .rst_ni, .job_i(job), .start_i(burst_start), .core_st_pending_i,
    .beat_taken_i(burst_taken), .beat_o(burst_beat), .beat_valid_o(burst_valid),
    .done_o(burst_done)
  );

  stride_stepper i_stride (
    .clk_i, .rst_ni, .job_i(job), .start_i(stride_start), .core_st_pending_i,
    .beat_taken_i(stride_taken), .beat_o(stride_beat), .beat_valid_o(stride_valid),
    .done_o(stride_done)
  );

  ax_issue i_issue (
    .burst_beat_i  (burst_beat),
    .burst_valid_i (burst_valid),
    .stride_beat_i (stride_beat),
    .stride_valid_i(stride_valid),
    .ar_ready_i    (ar_ready_i),
    .aw_ready_i    (aw_ready_i),
    .q_full_i      (q_full),
    .q_empty_i     (q_empty),
    .q_head_load_i (lsu_req_o.is_load),
    .ar_o          (ar_o),
    .ar_valid_o    (ar_valid_o),
    .aw_o          (aw_o),
    .aw_valid_o    (aw_valid_o),
    .q_push_o      (q_push),
    .q_data_o      (q_data),
    .burst_taken_o (burst_taken),
    .stride_taken_o(stride_taken)
  );

  // Head of the queue is what the LSUs see
  addr_queue #(
    .QueueDepth(QueueDepth),
    .dtype     (addrgen_pkg::ax_beat_t)
  ) i_queue (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (q_push),
    .data_i (q_data),
    .pop_i  (lsu_req_valid_o && lsu_req_ready_i),
    .data_o (lsu_req_o),
    .full_o (q_full),
    .empty_o(q_empty)
  );

  assign lsu_req_valid_o = !q_empty;

endmodule

//--- verif/tb_clock.sv
// Testbench clock source and power-on reset generator
`timescale 1ns/1ps

module tb_clock #(
  parameter int unsigned ClkPeriod   = 40,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  // Free-running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  // Reset held low for a fixed number of rising edges
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- verif/tb_addrgen.sv
// Directed testbench for the address generator with reference model and beat monitor
`timescale 1ns/1ps

module tb_addrgen;

  localparam int unsigned QueueDepth   = 4;
  localparam int unsigned AckTimeout   = 4000;
  localparam int unsigned DrainTimeout = 400;
  localparam int unsigned ResetTimeout = 50;

  logic                  clk;
  logic                  rst_n;
  addrgen_pkg::mem_req_t req_i;
  logic                  req_valid_i;
  logic                  core_st_pending_i;
  logic                  ack_o;
  logic                  error_o;
  addrgen_pkg::ax_beat_t ar_o;
  logic                  ar_valid_o;
  logic                  ar_ready_i;
  addrgen_pkg::ax_beat_t aw_o;
  logic                  aw_valid_o;
  logic                  aw_ready_i;
  addrgen_pkg::ax_beat_t lsu_req_o;
  logic                  lsu_req_valid_o;
  logic                  lsu_req_ready_i;

  // Beats still expected on AR/AW, and issued beats not yet seen by the LSUs
  addrgen_pkg::ax_beat_t exp_q[$];
  addrgen_pkg::ax_beat_t issued_q[$];
  int unsigned           beat_cnt;
  int unsigned           start_cnt;
  longint unsigned       cyc;
  longint unsigned       last_beat_cyc;
  logic [31:0]           lfsr_q;
  logic                  lsu_random;

  tb_clock #(
    .ClkPeriod  (40),
    .ResetCycles(8)
  ) i_clock (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  addrgen_top #(
    .QueueDepth(QueueDepth)
  ) i_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .req_i            (req_i),
    .req_valid_i      (req_valid_i),
    .core_st_pending_i(core_st_pending_i),
    .ack_o            (ack_o),
    .error_o          (error_o),
    .ar_o             (ar_o),
    .ar_valid_o       (ar_valid_o),
    .ar_ready_i       (ar_ready_i),
    .aw_o             (aw_o),
    .aw_valid_o       (aw_valid_o),
    .aw_ready_i       (aw_ready_i),
    .lsu_req_o        (lsu_req_o),
    .lsu_req_valid_o  (lsu_req_valid_o),
    .lsu_req_ready_i  (lsu_req_ready_i)
  );

  ////////////////////
  // Failure and compare helpers

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_beat(input string name, input addrgen_pkg::ax_beat_t got,
                            input addrgen_pkg::ax_beat_t exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1, shifts in at bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  ////////////////////
  // Ready drivers, cycle count and beat monitor

  always @(posedge clk) begin
    if (rst_n) begin
      // One LFSR step per ready bit
      lfsr_q = lfsr_next(lfsr_q);
      ar_ready_i <= lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
      aw_ready_i <= lfsr_q[0];
      if (lsu_random) begin
        lfsr_q = lfsr_next(lfsr_q);
        lsu_req_ready_i <= lfsr_q[0];
      end else begin
        lsu_req_ready_i <= 1'b0;
      end
    end
    cyc <= cyc + 1;
  end

  // Outputs settle by the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      // LSU pop first, a beat pushed now is not yet at the head
      if (lsu_req_valid_o && lsu_req_ready_i) begin
        if (issued_q.size() == 0) begin
          stop_on_failure("LSU queue offered a beat that was never issued");
        end
        check_beat("lsu_req_o", lsu_req_o, issued_q.pop_front());
      end
      if (ar_valid_o) begin
        if (exp_q.size() == 0) begin
          stop_on_failure("AR beat issued when no beat was expected");
        end
        check_beat("ar_o", ar_o, exp_q.pop_front());
        issued_q.push_back(ar_o);
        beat_cnt++;
        last_beat_cyc = cyc;
      end
      if (aw_valid_o) begin
        if (exp_q.size() == 0) begin
          stop_on_failure("AW beat issued when no beat was expected");
        end
        check_beat("aw_o", aw_o, exp_q.pop_front());
        issued_q.push_back(aw_o);
        beat_cnt++;
        last_beat_cyc = cyc;
      end
      // Error only ever comes with the acknowledge
      if (error_o) begin
        check_bit("ack_o", ack_o, 1'b1);
      end
    end
  end

  ////////////////////
  // Reference model

  // Unit-stride bytes cut at page ends and every MaxBurstBeats beats
  task automatic expect_unit_beats(input addrgen_pkg::addr_t addr, input addrgen_pkg::vl_t vl,
                                   input addrgen_pkg::vew_e vew, input logic is_load);
    longint unsigned       cur;
    longint unsigned       op_end;
    longint unsigned       first_beat;
    longint unsigned       page_next;
    longint unsigned       len_next;
    longint unsigned       stop;
    addrgen_pkg::ax_beat_t b;
    cur    = addr;
    op_end = longint'(addr) + (longint'(vl) << vew);
    while (cur < op_end) begin
      first_beat = cur - (cur % addrgen_pkg::DataBytes);
      page_next  = (cur | ((64'd1 << addrgen_pkg::PageBits) - 1)) + 1;
      len_next   = first_beat + addrgen_pkg::MaxBurstBeats * addrgen_pkg::DataBytes;
      stop       = op_end;
      if (page_next < stop) begin
        stop = page_next;
      end
      if (len_next < stop) begin
        stop = len_next;
      end
      b.addr    = addrgen_pkg::addr_t'(cur);
      b.len     = 8'((stop - 1 - first_beat) / addrgen_pkg::DataBytes);
      b.size    = 3'(addrgen_pkg::DataBytesLog);
      b.is_load = is_load;
      exp_q.push_back(b);
      cur = stop;
    end
  endtask

  // One single-beat request per element at base + k * stride
  task automatic expect_stride_beats(input addrgen_pkg::addr_t addr, input addrgen_pkg::vl_t vl,
                                     input addrgen_pkg::addr_t stride,
                                     input addrgen_pkg::vew_e vew, input logic is_load);
    addrgen_pkg::ax_beat_t b;
    for (int unsigned k = 0; k < vl; k++) begin
      b.addr    = addr + addrgen_pkg::addr_t'(k) * stride;
      b.len     = 8'd0;
      b.size    = 3'(vew);
      b.is_load = is_load;
      exp_q.push_back(b);
    end
  endtask

  function automatic addrgen_pkg::mem_req_t make_req(input addrgen_pkg::mem_op_e op,
                                                     input addrgen_pkg::addr_t addr,
                                                     input addrgen_pkg::vl_t vl,
                                                     input addrgen_pkg::addr_t stride,
                                                     input addrgen_pkg::vew_e vew);
    addrgen_pkg::mem_req_t r;
    r.op     = op;
    r.addr   = addr;
    r.vl     = vl;
    r.stride = stride;
    r.vew    = vew;
    return r;
  endfunction

  ////////////////////
  // Request sequencing

  task automatic start_request(input addrgen_pkg::mem_req_t r);
    @(posedge clk);
    req_i       <= r;
    req_valid_i <= 1'b1;
    start_cnt = beat_cnt;
  endtask

  // Request stays valid until the acknowledge, then drops
  task automatic wait_ack(input logic exp_err);
    int unsigned     n;
    logic            seen;
    longint unsigned ack_cyc;
    n    = 0;
    seen = 1'b0;
    while (!seen && (n < AckTimeout)) begin
      @(negedge clk);
      n++;
      if (ack_o) begin
        seen    = 1'b1;
        ack_cyc = cyc;
      end
    end
    if (!seen) begin
      stop_on_failure("no acknowledge arrived within the timeout");
    end
    check_bit("error_o", error_o, exp_err);
    @(posedge clk);
    req_valid_i <= 1'b0;
    if (exp_q.size() != 0) begin
      stop_on_failure($sformatf("acknowledge came with %0d beats missing", exp_q.size()));
    end
    if (!exp_err && (ack_cyc - last_beat_cyc != 1)) begin
      stop_on_failure("acknowledge did not follow the last beat by one cycle");
    end
  endtask

  task automatic run_unit(input addrgen_pkg::mem_op_e op, input addrgen_pkg::addr_t addr,
                          input addrgen_pkg::vl_t vl, input addrgen_pkg::vew_e vew);
    expect_unit_beats(addr, vl, vew, op == addrgen_pkg::OP_UNIT_LOAD);
    start_request(make_req(op, addr, vl, '0, vew));
    wait_ack(1'b0);
  endtask

  task automatic run_stride(input addrgen_pkg::mem_op_e op, input addrgen_pkg::addr_t addr,
                            input addrgen_pkg::vl_t vl, input addrgen_pkg::addr_t stride,
                            input addrgen_pkg::vew_e vew);
    expect_stride_beats(addr, vl, stride, vew, op == addrgen_pkg::OP_STRIDE_LOAD);
    start_request(make_req(op, addr, vl, stride, vew));
    wait_ack(1'b0);
  endtask

  // Fixed window where no store beat and no acknowledge may appear
  task automatic observe_stall(input int unsigned cycles, input logic allow_ar);
    repeat (cycles) begin
      @(negedge clk);
      check_bit("ack_o", ack_o, 1'b0);
      check_bit("aw_valid_o", aw_valid_o, 1'b0);
      if (!allow_ar) begin
        check_bit("ar_valid_o", ar_valid_o, 1'b0);
      end
    end
  endtask

  task automatic drain_queue();
    int unsigned n;
    n = 0;
    lsu_random <= 1'b1;
    while ((issued_q.size() != 0) && (n < DrainTimeout)) begin
      @(posedge clk);
      n++;
    end
    if (issued_q.size() != 0) begin
      stop_on_failure("LSU queue did not drain within the timeout");
    end
  endtask

  ////////////////////
  // Directed tests

  task automatic test_misaligned();
    start_request(make_req(addrgen_pkg::OP_UNIT_LOAD, 32'h0000_1002, 16'd8, '0,
                           addrgen_pkg::EW32));
    wait_ack(1'b1);
    start_request(make_req(addrgen_pkg::OP_STRIDE_STORE, 32'h0000_2001, 16'd4, 32'h10,
                           addrgen_pkg::EW16));
    wait_ack(1'b1);
  endtask

  task automatic test_unit_split();
    // Page crossing, then the 256 beat limit, then an unaligned page crossing
    run_unit(addrgen_pkg::OP_UNIT_LOAD, 32'h0000_0fe4, 16'd40, addrgen_pkg::EW32);
    run_unit(addrgen_pkg::OP_UNIT_LOAD, 32'h0000_3008, 16'd300, addrgen_pkg::EW64);
    run_unit(addrgen_pkg::OP_UNIT_LOAD, 32'h0000_5ffa, 16'd9, addrgen_pkg::EW16);
    run_unit(addrgen_pkg::OP_UNIT_STORE, 32'h0000_7ff3, 16'd30, addrgen_pkg::EW8);
  endtask

  task automatic test_stride_store();
    run_stride(addrgen_pkg::OP_STRIDE_STORE, 32'h0000_8000, 16'd7, 32'h24, addrgen_pkg::EW32);
    // Negative stride walks down
    run_stride(addrgen_pkg::OP_STRIDE_STORE, 32'h0000_9000, 16'd5, 32'hffff_fff0,
               addrgen_pkg::EW64);
  endtask

  task automatic test_store_pending();
    @(posedge clk);
    core_st_pending_i <= 1'b1;
    expect_stride_beats(32'h0000_a100, 16'd4, 32'h8, addrgen_pkg::EW16, 1'b0);
    start_request(make_req(addrgen_pkg::OP_STRIDE_STORE, 32'h0000_a100, 16'd4, 32'h8,
                           addrgen_pkg::EW16));
    observe_stall(20, 1'b0);
    @(posedge clk);
    core_st_pending_i <= 1'b0;
    wait_ack(1'b0);
    // Same hold on the burst path
    @(posedge clk);
    core_st_pending_i <= 1'b1;
    expect_unit_beats(32'h0000_b000, 16'd12, addrgen_pkg::EW32, 1'b0);
    start_request(make_req(addrgen_pkg::OP_UNIT_STORE, 32'h0000_b000, 16'd12, '0,
                           addrgen_pkg::EW32));
    observe_stall(20, 1'b0);
    @(posedge clk);
    core_st_pending_i <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic test_queue_order();
    drain_queue();
    lsu_random <= 1'b0;
    // Queue full stops issue at QueueDepth beats
    expect_stride_beats(32'h0001_0000, 16'd6, 32'h40, addrgen_pkg::EW64, 1'b1);
    start_request(make_req(addrgen_pkg::OP_STRIDE_LOAD, 32'h0001_0000, 16'd6, 32'h40,
                           addrgen_pkg::EW64));
    observe_stall(40, 1'b1);
    @(posedge clk);
    if (beat_cnt - start_cnt != QueueDepth) begin
      stop_on_failure($sformatf("%0d beats issued into a queue of depth %0d",
                                beat_cnt - start_cnt, QueueDepth));
    end
    lsu_random <= 1'b1;
    wait_ack(1'b0);
    drain_queue();
    // Loads left queued block a following store
    lsu_random <= 1'b0;
    run_stride(addrgen_pkg::OP_STRIDE_LOAD, 32'h0002_0000, 16'd2, 32'h8, addrgen_pkg::EW32);
    expect_stride_beats(32'h0003_0000, 16'd3, 32'h4, addrgen_pkg::EW32, 1'b0);
    start_request(make_req(addrgen_pkg::OP_STRIDE_STORE, 32'h0003_0000, 16'd3, 32'h4,
                           addrgen_pkg::EW32));
    observe_stall(20, 1'b0);
    lsu_random <= 1'b1;
    wait_ack(1'b0);
    drain_queue();
  endtask

  ////////////////////
  // Main sequence

  initial begin
    int unsigned n;
    req_i             = '0;
    req_valid_i       = 1'b0;
    core_st_pending_i = 1'b0;
    ar_ready_i        = 1'b0;
    aw_ready_i        = 1'b0;
    lsu_req_ready_i   = 1'b0;
    lfsr_q            = 32'hfdb9;
    lsu_random        = 1'b1;
    beat_cnt          = 0;
    start_cnt         = 0;
    cyc               = 0;
    last_beat_cyc     = 0;
    n                 = 0;
    while (!rst_n && (n < ResetTimeout)) begin
      @(negedge clk);
      n++;
    end
    if (!rst_n) begin
      stop_on_failure("reset was never released");
    end
    // Quiet outputs straight out of reset
    check_bit("ack_o", ack_o, 1'b0);
    check_bit("error_o", error_o, 1'b0);
    check_bit("ar_valid_o", ar_valid_o, 1'b0);
    check_bit("aw_valid_o", aw_valid_o, 1'b0);
    check_bit("lsu_req_valid_o", lsu_req_valid_o, 1'b0);
    test_misaligned();
    test_unit_split();
    test_stride_store();
    test_store_pending();
    test_queue_order();
    drain_queue();
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- files.f
logic/addrgen_pkg.sv
logic/addr_queue.sv
logic/op_decoder.sv
logic/burst_splitter.sv
logic/stride_stepper.sv
logic/ax_issue.sv
logic/addrgen_top.sv
verif/tb_clock.sv
verif/tb_addrgen.sv
